//--- project.f
hdl/otter_pkg.sv
hdl/otter_ctrl_if.sv
hdl/otter_decoder.sv
hdl/otter_fsm.sv
hdl/otter_pc.sv
hdl/otter_rfile.sv
hdl/otter_imm_gen.sv
hdl/otter_alu.sv
hdl/otter_branch_unit.sv
hdl/otter_mcu.sv
bench/tb_otter_mcu.sv
+incdir+bench

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_otter_mcu
FILELIST  = project.f
SIM       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

$(SIM): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "^test passed$$"

clean:
	rm -rf obj_dir

//--- bench/tb_iss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

//////////////////////////////
// Instruction encoders
//////////////////////////////

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

// Word store only
function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

//////////////////////////////
// Reference model
//////////////////////////////

// Galois LFSR, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int k = 0; k < n; k++) begin
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        end
        val = {val[30:0], lsb};
    end
    return val;
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        3'd7: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// Runs imem on an architectural model, fills the expected store queues
function automatic void run_model();
    logic [31:0] x [32];
    logic [31:0] mem [1024];
    logic [31:0] pc, ins, a, b, res, nxt, addr;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic        wr;
    logic        done;
    int          cyc;
    mem = dmem_init;
    for (int r = 0; r < NUM_REGS; r++) begin
        x[r] = '0;
    end
    exp_addr.delete();
    exp_data.delete();
    exp_cyc.delete();
    pc   = RESET_VEC;
    cyc  = 1;
    done = 1'b0;
    for (int steps = 0; steps < 20000 && !done; steps++) begin
        ins   = imem[pc[11:2]];
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = pc + 32'd4;
        wr    = 1'b1;
        res   = '0;
        case (ins[6:0])
            7'b0110111: res = imm_u;
            7'b0010111: res = pc + imm_u;
            7'b1101111: begin
                res = pc + 32'd4;
                nxt = pc + imm_j;
            end
            7'b1100111: begin
                res = pc + 32'd4;
                nxt = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                if (branch_ref(ins[14:12], a, b)) begin
                    nxt = pc + imm_b;
                end
            end
            7'b0000011: begin
                // Extra WR_BK cycle
                addr = a + imm_i;
                res  = mem[addr[11:2]];
                cyc  = cyc + 1;
            end
            7'b0100011: begin
                wr   = 1'b0;
                addr = a + imm_s;
                mem[addr[11:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
                exp_cyc.push_back(cyc);
                done = (addr == MARKER_ADDR);
            end
            7'b0010011: res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
            7'b0110011: res = alu_ref(ins[14:12], ins[30], a, b);
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = res;
        end
        pc  = nxt;
        cyc = cyc + 1;
    end
endfunction

`endif

//--- bench/tb_otter_mcu.sv
`timescale 1ns/100ps

module tb_otter_mcu import otter_pkg::*; ();

    localparam logic [31:0] MARKER_ADDR = 32'hFFFF_FFFC;
    localparam int          TIMEOUT     = 20000;

    logic        clk = 1'b0;
    logic        rst = 1'b0;
    logic [31:0] imem_r_data = '0;
    logic [31:0] dmem_r_data = '0;
    logic [31:0] imem_addr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_w_data;
    logic        dmem_re;
    logic        dmem_we;

    // Memories and their registered addresses
    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];
    logic [31:0] dmem_init [1024];
    logic [31:0] imem_addr_q = '0;
    logic [31:0] dmem_addr_q = '0;

    // Expected stores from the model
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_cyc [$];
    int          exp_idx = 0;
    int          cyc = 0;
    int          rst_cnt = 0;
    int          marker_cnt = 0;

    logic [31:0] lfsr_state = 32'h5464_8540;
    logic [9:0]  emit_pos;
    logic [11:0] st_off;

    `include "tb_iss.svh"

    otter_mcu uut (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_imem_r_data (imem_r_data),
        .o_imem_addr   (imem_addr),
        .i_dmem_r_data (dmem_r_data),
        .o_dmem_re     (dmem_re),
        .o_dmem_we     (dmem_we),
        .o_dmem_addr   (dmem_addr),
        .o_dmem_w_data (dmem_w_data)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // Memory models
    //////////////////////////////

    // Capture on the rising edge and answer on the falling edge
    always @(posedge clk) begin
        imem_addr_q <= imem_addr;
        if (dmem_re) begin
            dmem_addr_q <= dmem_addr;
        end
        if (!rst) begin
            for (int i = 0; i < 1024; i++) begin
                dmem[10'(i)] <= dmem_init[10'(i)];
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[11:2]] <= dmem_w_data;
        end
    end

    always @(negedge clk) begin
        imem_r_data <= imem[imem_addr_q[11:2]];
        dmem_r_data <= dmem[dmem_addr_q[11:2]];
    end

    // Cycle 0 is the INIT cycle after release
    always @(posedge clk) begin
        if (!rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    // Compare process for reset quiet, first fetch and every store
    always @(posedge clk) begin
        if (!rst) begin
            if (rst_cnt > 0) begin
                check_value("o_dmem_re", {31'b0, dmem_re}, 32'd0);
                check_value("o_dmem_we", {31'b0, dmem_we}, 32'd0);
            end
            rst_cnt <= rst_cnt + 1;
            exp_idx <= 0;
        end else begin
            rst_cnt <= 0;
            if (cyc == 0) begin
                check_value("o_imem_addr", imem_addr, RESET_VEC);
            end
            if (dmem_we) begin
                if (exp_idx >= exp_addr.size()) begin
                    fail_run("The DUT made a store that the model does not expect");
                end else begin
                    check_value("o_dmem_addr", dmem_addr, exp_addr[exp_idx]);
                    check_value("o_dmem_w_data", dmem_w_data, exp_data[exp_idx]);
                    check_value("store cycle", 32'(cyc), 32'(exp_cyc[exp_idx]));
                    exp_idx <= exp_idx + 1;
                    if (dmem_addr == MARKER_ADDR) begin
                        marker_cnt <= marker_cnt + 1;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // Program builders
    //////////////////////////////

    function automatic void emit(input logic [31:0] w);
        imem[emit_pos] = w;
        emit_pos = emit_pos + 10'd1;
    endfunction

    // Result stores walk up from 0x400
    function automatic void store_result(input logic [4:0] rs);
        emit(enc_s(st_off, rs, 5'd0));
        st_off = st_off + 12'd4;
    endfunction

    function automatic void clear_program();
        for (int i = 0; i < 1024; i++) begin
            imem[10'(i)] = '0;
        end
        emit_pos = '0;
        st_off   = 12'h400;
    endfunction

    // Marker store then jump to self
    function automatic void finish_program();
        emit(enc_s(12'hFFC, 5'd3, 5'd0));
        emit(enc_j(21'd0, 5'd0));
    endfunction

    function automatic void build_directed();
        logic [2:0] f3;
        clear_program();
        emit(enc_u(20'h87654, 5'd1, OPC_LUI));
        emit(enc_i(12'h321, 5'd1, 3'd0, 5'd1, OPC_OP_IMM));
        emit(enc_i(12'hFFB, 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
        emit(enc_i(12'h007, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
        // Register-immediate ops with shifts by 9
        for (int k = 0; k < 8; k++) begin
            f3 = 3'(k);
            emit(enc_i((f3 == 3'd1 || f3 == 3'd5) ? 12'h009 : 12'hF9C, 5'd1, f3, 5'd4,
                       OPC_OP_IMM));
            store_result(5'd4);
        end
        emit(enc_i(12'h409, 5'd1, 3'd5, 5'd4, OPC_OP_IMM));
        store_result(5'd4);
        // Register-register ops then SUB and SRA
        for (int k = 0; k < 8; k++) begin
            emit(enc_r(7'h00, 5'd2, 5'd1, 3'(k), 5'd4));
            store_result(5'd4);
        end
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));
        store_result(5'd4);
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd4));
        store_result(5'd4);
        emit(enc_u(20'hABCDE, 5'd4, OPC_LUI));
        store_result(5'd4);
        emit(enc_u(20'h12345, 5'd4, OPC_AUIPC));
        store_result(5'd4);
        // Each branch on three operand pairs where x5 shows the path
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                emit(enc_i(12'd1, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
                emit(enc_b(13'd8, (p == 1) ? 5'd1 : 5'd3, (p == 0) ? 5'd1 : 5'd3,
                           3'(k < 2 ? k : k + 2)));
                emit(enc_i(12'd2, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
                store_result(5'd5);
            end
        end
        // JAL skips one instruction
        emit(enc_j(21'd8, 5'd6));
        emit(enc_i(12'd0, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
        store_result(5'd6);
        // JALR to an odd address drops bit 0
        emit(enc_u(20'h0, 5'd7, OPC_AUIPC));
        emit(enc_i(12'd13, 5'd7, 3'd0, 5'd8, OPC_JALR));
        emit(enc_i(12'd0, 5'd0, 3'd0, 5'd8, OPC_OP_IMM));
        store_result(5'd8);
        // Load used right away then load stored right away
        emit(enc_i(12'h600, 5'd0, 3'd2, 5'd9, OPC_LOAD));
        emit(enc_i(12'd1, 5'd9, 3'd0, 5'd9, OPC_OP_IMM));
        store_result(5'd9);
        emit(enc_i(12'h604, 5'd0, 3'd2, 5'd10, OPC_LOAD));
        store_result(5'd10);
        finish_program();
    endfunction

    function automatic void build_random();
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        clear_program();
        // Every register gets a known value first
        for (int r = 1; r < NUM_REGS; r++) begin
            emit(enc_u(20'(rand_bits(20)), 5'(r), OPC_LUI));
            emit(enc_i(12'(rand_bits(12)), 5'(r), 3'd0, 5'(r), OPC_OP_IMM));
        end
        for (int n = 0; n < 150; n++) begin
            rd  = 5'(rand_bits(5));
            rs1 = 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            f3  = 3'(rand_bits(3));
            imm = 12'(rand_bits(12));
            alt = (rand_bits(1) == 32'd1) && (f3 == 3'd0 || f3 == 3'd5);
            case (rand_bits(2))
                32'd0: emit(enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd));
                32'd1: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm[11:5] = {1'b0, alt && f3 == 3'd5, 5'b0};
                    end
                    emit(enc_i(imm, rs1, f3, rd, OPC_OP_IMM));
                end
                32'd2: emit(enc_i({2'b01, imm[7:0], 2'b00}, 5'd0, 3'd2, rd, OPC_LOAD));
                default: emit(enc_s({2'b01, imm[7:0], 2'b00}, rs2, 5'd0));
            endcase
        end
        finish_program();
    endfunction

    //////////////////////////////
    // Run control
    //////////////////////////////

    task automatic run_program(input string name);
        int start;
        int t;
        run_model();
        start = marker_cnt;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        t = 0;
        while (marker_cnt == start && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (marker_cnt == start) begin
            fail_run({"The ", name, " program never finished"});
        end
    endtask

    initial begin
        for (int i = 0; i < 1024; i++) begin
            dmem_init[10'(i)] = (32'(i) * 32'h9E37_79B9) ^ 32'hC3A5_0000;
        end
        build_directed();
        run_program("directed");
        // Hold the core in reset while imem is rewritten
        @(negedge clk);
        rst = 1'b0;
        build_random();
        run_program("random");
        $display("test passed");
        $finish;
    end

endmodule

//--- hdl/otter_mcu.sv
`timescale 1ns/100ps

module otter_mcu import otter_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  xlen_t  i_imem_r_data,
    output xlen_t  o_imem_addr,
    input  xlen_t  i_dmem_r_data,
    output logic   o_dmem_re,
    output logic   o_dmem_we,
    output xlen_t  o_dmem_addr,
    output xlen_t  o_dmem_w_data
);

    otter_ctrl_if ctrl ();

    xlen_t   pc;
    xlen_t   target;
    instr_u  instr;
    logic    stall;
    pc_src_e pc_src;
    logic    br_taken;
    logic    rf_we;
    xlen_t   rs1;
    xlen_t   rs2;
    xlen_t   imm;
    xlen_t   alu_a;
    xlen_t   alu_b;
    xlen_t   alu_result;
    xlen_t   wb_data;

    //////////////////////////////
    // Fetch and control
    //////////////////////////////

    otter_pc u_pc (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_stall       (stall),
        .i_pc_src      (pc_src),
        .i_target      (target),
        .i_imem_r_data (i_imem_r_data),
        .o_pc          (pc),
        .o_imem_addr   (o_imem_addr),
        .o_instr       (instr)
    );

    otter_decoder u_decoder (
        .i_instr (instr),
        .ctrl    (ctrl)
    );

    otter_fsm u_fsm (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .ctrl       (ctrl),
        .i_br_taken (br_taken),
        .o_rf_we    (rf_we),
        .o_dmem_re  (o_dmem_re),
        .o_dmem_we  (o_dmem_we),
        .o_stall    (stall),
        .o_pc_src   (pc_src)
    );

    //////////////////////////////
    // Register file and operands
    //////////////////////////////

    otter_rfile u_rfile (
        .i_clk      (i_clk),
        .i_rs1_addr (instr.r.rs1),
        .i_rs2_addr (instr.r.rs2),
        .i_rd_addr  (instr.r.rd),
        .i_we       (rf_we),
        .i_w_data   (wb_data),
        .o_rs1      (rs1),
        .o_rs2      (rs2)
    );

    otter_imm_gen u_imm_gen (
        .i_instr   (instr),
        .i_imm_sel (ctrl.imm_sel),
        .o_imm     (imm)
    );

    // Source A is PC only for AUIPC
    assign alu_a = ctrl.alu_src_a_pc ? pc : rs1;
    assign alu_b = ctrl.alu_src_b_imm ? imm : rs2;

    otter_alu u_alu (
        .i_a      (alu_a),
        .i_b      (alu_b),
        .i_func   (ctrl.alu_func),
        .o_result (alu_result)
    );

    otter_branch_unit u_branch_unit (
        .i_instr    (instr),
        .i_pc       (pc),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_imm      (imm),
        .i_is_jalr  (ctrl.is_jalr),
        .o_br_taken (br_taken),
        .o_target   (target)
    );

    //////////////////////////////
    // Writeback and data memory
    //////////////////////////////

    always_comb begin
        case (ctrl.wb_sel)
            WB_PC_PLUS4: wb_data = pc + 32'd4;
            // Load data arrives during WR_BK
            WB_DMEM:     wb_data = i_dmem_r_data;
            default:     wb_data = alu_result;
        endcase
    end

    // Loads and stores address with rs1 + imm from the ALU
    assign o_dmem_addr   = alu_result;
    assign o_dmem_w_data = rs2;

endmodule

//--- hdl/otter_branch_unit.sv
`timescale 1ns/100ps

module otter_branch_unit import otter_pkg::*; (
    input  instr_u  i_instr,
    input  xlen_t   i_pc,
    input  xlen_t   i_rs1,
    input  xlen_t   i_rs2,
    input  xlen_t   i_imm,
    input  logic    i_is_jalr,
    output logic    o_br_taken,
    output xlen_t   o_target
);

    xlen_t jalr_sum;

    // Condition from funct3, only used when the FSM sees a branch
    always_comb begin
        case (i_instr.b.funct3)
            F3_BEQ:  o_br_taken = (i_rs1 == i_rs2);
            F3_BNE:  o_br_taken = (i_rs1 != i_rs2);
            F3_BLT:  o_br_taken = ($signed(i_rs1) < $signed(i_rs2));
            F3_BGE:  o_br_taken = ($signed(i_rs1) >= $signed(i_rs2));
            F3_BLTU: o_br_taken = (i_rs1 < i_rs2);
            F3_BGEU: o_br_taken = (i_rs1 >= i_rs2);
            default: o_br_taken = 1'b0;
        endcase
    end

    assign jalr_sum = i_rs1 + i_imm;

    // JALR drops bit 0, JAL and branches are PC relative
    assign o_target = i_is_jalr ? {jalr_sum[31:1], 1'b0} : (i_pc + i_imm);

endmodule

//--- hdl/otter_alu.sv
`timescale 1ns/100ps

module otter_alu import otter_pkg::*; (
    input  xlen_t      i_a,
    input  xlen_t      i_b,
    input  alu_func_e  i_func,
    output xlen_t      o_result
);

    logic [4:0] shamt;

    // Shift amount from the low bits of B only
    assign shamt = i_b[4:0];

    always_comb begin
        case (i_func)
            ALU_ADD:      o_result = i_a + i_b;
            ALU_SUB:      o_result = i_a - i_b;
            ALU_SLL:      o_result = i_a << shamt;
            ALU_SLT:      o_result = {31'b0, $signed(i_a) < $signed(i_b)};
            ALU_SLTU:     o_result = {31'b0, i_a < i_b};
            ALU_XOR:      o_result = i_a ^ i_b;
            ALU_SRL:      o_result = i_a >> shamt;
            ALU_SRA:      o_result = $signed(i_a) >>> shamt;
            ALU_OR:       o_result = i_a | i_b;
            ALU_AND:      o_result = i_a & i_b;
            // LUI result is the U immediate as is
            ALU_LUI_COPY: o_result = i_b;
            default:      o_result = '0;
        endcase
    end

endmodule

//--- hdl/otter_imm_gen.sv
`timescale 1ns/100ps

module otter_imm_gen import otter_pkg::*; (
    input  instr_u    i_instr,
    input  imm_sel_e  i_imm_sel,
    output xlen_t     o_imm
);

    always_comb begin
        case (i_imm_sel)
            IMM_I: o_imm = {{20{i_instr.i.imm_11_0[11]}}, i_instr.i.imm_11_0};
            IMM_S: o_imm = {{20{i_instr.s.imm_11_5[6]}}, i_instr.s.imm_11_5,
                            i_instr.s.imm_4_0};
            // Branch offsets are even, bit 0 always zero
            IMM_B: o_imm = {{19{i_instr.b.imm_12}}, i_instr.b.imm_12, i_instr.b.imm_11,
                            i_instr.b.imm_10_5, i_instr.b.imm_4_1, 1'b0};
            // Upper 20 bits, low 12 cleared
            IMM_U: o_imm = {i_instr.u.imm_31_12, 12'b0};
            IMM_J: o_imm = {{11{i_instr.j.imm_20}}, i_instr.j.imm_20, i_instr.j.imm_19_12,
                            i_instr.j.imm_11, i_instr.j.imm_10_1, 1'b0};
            default: o_imm = '0;
        endcase
    end

endmodule

//--- hdl/otter_rfile.sv
`timescale 1ns/100ps

module otter_rfile import otter_pkg::*; (
    input  logic       i_clk,
    input  reg_addr_t  i_rs1_addr,
    input  reg_addr_t  i_rs2_addr,
    input  reg_addr_t  i_rd_addr,
    input  logic       i_we,
    input  xlen_t      i_w_data,
    output xlen_t      o_rs1,
    output xlen_t      o_rs2
);

    xlen_t regs [NUM_REGS];

    // Single write port, x0 never written
    always_ff @(posedge i_clk) begin
        if (i_we && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_w_data;
        end
    end

    // Async reads, x0 forced to zero
    assign o_rs1 = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2 = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- hdl/otter_pc.sv
`timescale 1ns/100ps

module otter_pc import otter_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_stall,
    input  pc_src_e  i_pc_src,
    input  xlen_t    i_target,
    input  xlen_t    i_imem_r_data,
    output xlen_t    o_pc,
    output xlen_t    o_imem_addr,
    output instr_u   o_instr
);

    xlen_t pc_next;
    xlen_t instr_q;
    logic  stall_q;

    always_comb begin
        case (i_pc_src)
            PC_INC:    pc_next = o_pc + 32'd4;
            PC_TARGET: pc_next = i_target;
            default:   pc_next = RESET_VEC;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_pc    <= RESET_VEC;
            stall_q <= 1'b0;
        end else begin
            if (!i_stall) begin
                o_pc <= pc_next;
            end
            stall_q <= i_stall;
        end
    end

    // Fetch ahead with the next PC, or refetch the current one on a stall
    assign o_imem_addr = i_stall ? o_pc : pc_next;

    // Keep the load's instruction for WR_BK
    always_ff @(posedge i_clk) begin
        instr_q <= o_instr;
    end

    assign o_instr = stall_q ? instr_q : i_imem_r_data;

endmodule

//--- hdl/otter_fsm.sv
`timescale 1ns/100ps

module otter_fsm import otter_pkg::*; (
    input  logic           i_clk,
    input  logic           i_rst,
    otter_ctrl_if.fsm      ctrl,
    input  logic           i_br_taken,
    output logic           o_rf_we,
    output logic           o_dmem_re,
    output logic           o_dmem_we,
    output logic           o_stall,
    output pc_src_e        o_pc_src
);

    state_e state;
    state_e state_nxt;

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state <= ST_INIT;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        // Everything idle unless a state says otherwise
        o_rf_we   = 1'b0;
        o_dmem_re = 1'b0;
        o_dmem_we = 1'b0;
        o_stall   = 1'b0;
        o_pc_src  = PC_RESET;
        state_nxt = ST_INIT;

        case (state)
            ST_INIT: begin
                // Fetch from the reset vector
                o_pc_src  = PC_RESET;
                state_nxt = ST_EXEC;
            end
            ST_EXEC: begin
                o_rf_we   = ctrl.rf_we;
                o_dmem_re = ctrl.dmem_re;
                o_dmem_we = ctrl.dmem_we;

                if (ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && i_br_taken)) begin
                    o_pc_src = PC_TARGET;
                end else begin
                    o_pc_src = PC_INC;
                end

                // Load holds the PC one extra cycle for its data
                if (ctrl.is_load) begin
                    o_stall   = 1'b1;
                    state_nxt = ST_WR_BK;
                end else begin
                    state_nxt = ST_EXEC;
                end
            end
            ST_WR_BK: begin
                o_rf_we   = 1'b1;
                o_pc_src  = PC_INC;
                state_nxt = ST_EXEC;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/otter_decoder.sv
`timescale 1ns/100ps

module otter_decoder import otter_pkg::*; (
    input  instr_u         i_instr,
    otter_ctrl_if.dec      ctrl
);

    logic [2:0] funct3;
    logic       f7_alt;

    assign funct3 = i_instr.r.funct3;
    // Bit 30 selects SUB and SRA
    assign f7_alt = i_instr.r.funct7[5];

    always_comb begin
        // No-op defaults, also used for unknown opcodes
        ctrl.alu_func      = ALU_ADD;
        ctrl.alu_src_a_pc  = 1'b0;
        ctrl.alu_src_b_imm = 1'b0;
        ctrl.imm_sel       = IMM_I;
        ctrl.wb_sel        = WB_ALU;
        ctrl.is_branch     = 1'b0;
        ctrl.is_jal        = 1'b0;
        ctrl.is_jalr       = 1'b0;
        ctrl.is_load       = 1'b0;
        ctrl.rf_we         = 1'b0;
        ctrl.dmem_re       = 1'b0;
        ctrl.dmem_we       = 1'b0;

        case (i_instr.r.opcode)
            OPC_LUI: begin
                ctrl.alu_func      = ALU_LUI_COPY;
                ctrl.alu_src_b_imm = 1'b1;
                ctrl.imm_sel       = IMM_U;
                ctrl.rf_we         = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.alu_src_a_pc  = 1'b1;
                ctrl.alu_src_b_imm = 1'b1;
                ctrl.imm_sel       = IMM_U;
                ctrl.rf_we         = 1'b1;
            end
            OPC_JAL: begin
                // Link value is PC+4, target from branch unit
                ctrl.imm_sel = IMM_J;
                ctrl.wb_sel  = WB_PC_PLUS4;
                ctrl.is_jal  = 1'b1;
                ctrl.rf_we   = 1'b1;
            end
            OPC_JALR: begin
                ctrl.imm_sel = IMM_I;
                ctrl.wb_sel  = WB_PC_PLUS4;
                ctrl.is_jalr = 1'b1;
                ctrl.rf_we   = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.imm_sel   = IMM_B;
                ctrl.is_branch = 1'b1;
            end
            OPC_LOAD: begin
                // Register write happens in WR_BK, not here
                ctrl.alu_src_b_imm = 1'b1;
                ctrl.imm_sel       = IMM_I;
                ctrl.wb_sel        = WB_DMEM;
                ctrl.is_load       = 1'b1;
                ctrl.dmem_re       = 1'b1;
            end
            OPC_STORE: begin
                ctrl.alu_src_b_imm = 1'b1;
                ctrl.imm_sel       = IMM_S;
                ctrl.dmem_we       = 1'b1;
            end
            OPC_OP_IMM: begin
                // Imm bit 30 only means SRAI on a right shift
                ctrl.alu_func      = alu_func_e'({(funct3 == F3_SR) & f7_alt, funct3});
                ctrl.alu_src_b_imm = 1'b1;
                ctrl.imm_sel       = IMM_I;
                ctrl.rf_we         = 1'b1;
            end
            OPC_OP: begin
                ctrl.alu_func = alu_func_e'({f7_alt, funct3});
                ctrl.rf_we    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/otter_ctrl_if.sv
`timescale 1ns/100ps

interface otter_ctrl_if import otter_pkg::*; ();

    // Datapath selects
    alu_func_e alu_func;
    logic      alu_src_a_pc;
    logic      alu_src_b_imm;
    imm_sel_e  imm_sel;
    wb_sel_e   wb_sel;

    // Instruction class flags
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      is_load;

    // Raw enables, gated later by the FSM
    logic      rf_we;
    logic      dmem_re;
    logic      dmem_we;

    modport dec (
        output alu_func, alu_src_a_pc, alu_src_b_imm, imm_sel, wb_sel,
        output is_branch, is_jal, is_jalr, is_load,
        output rf_we, dmem_re, dmem_we
    );

    modport fsm (
        input is_branch, is_jal, is_jalr, is_load,
        input rf_we, dmem_re, dmem_we
    );

    modport dp (
        input alu_func, alu_src_a_pc, alu_src_b_imm, imm_sel, wb_sel, is_jalr
    );

endinterface

//--- hdl/otter_pkg.sv
package otter_pkg;

    //////////////////////////////
    // Basic word types
    //////////////////////////////

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    localparam xlen_t RESET_VEC = 32'h0000_0000;
    localparam int    NUM_REGS  = 32;

    // RV32I major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Branch funct3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    // Shift right, funct7[5] picks arithmetic
    localparam logic [2:0] F3_SR   = 3'b101;

    //////////////////////////////
    // Control select codes
    //////////////////////////////

    // Encoded as {funct7[5], funct3} so OP maps straight across
    typedef enum logic [3:0] {
        ALU_ADD      = 4'b0000,
        ALU_SUB      = 4'b1000,
        ALU_SLL      = 4'b0001,
        ALU_SLT      = 4'b0010,
        ALU_SLTU     = 4'b0011,
        ALU_XOR      = 4'b0100,
        ALU_SRL      = 4'b0101,
        ALU_SRA      = 4'b1101,
        ALU_OR       = 4'b0110,
        ALU_AND      = 4'b0111,
        ALU_LUI_COPY = 4'b1001
    } alu_func_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    typedef enum logic [1:0] {WB_PC_PLUS4, WB_DMEM, WB_ALU} wb_sel_e;

    typedef enum logic [1:0] {PC_RESET, PC_INC, PC_TARGET} pc_src_e;

    typedef enum logic [1:0] {ST_INIT, ST_EXEC, ST_WR_BK} state_e;

    //////////////////////////////
    // Instruction word formats
    //////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // Same 32 bits, one view per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage
